/* project.f */
hdl/itlb_pkg.sv
hdl/itlb_plru.sv
hdl/itlb_entry_array.sv
hdl/itlb_lookup_stage.sv
hdl/itlb_ctrl.sv
hdl/itlb_top.sv
verification/itlb_tb.sv

/* verification/itlb_golden.txt */
# asid vpn mode hit | L2 pte ppn, flags dguxwrv (binary), is_mem | expected ppn page_fault access_fault
# mode 0 user, 1 supervisor; hit 0 means the lookup goes to the L2 first
# first fill, then repeated hits
001 10000 1 0 000100 0001011 1 000100 0 0
001 10000 1 1 000100 0001011 1 000100 0 0
001 10000 1 1 000100 0001011 1 000100 0 0
001 10000 1 1 000100 0001011 1 000100 0 0
# fault rules on fill and replay
001 10001 1 0 000101 0001010 1 000101 1 0
001 10002 1 0 000102 0000011 1 000102 1 0
001 10004 1 0 000104 0001101 1 000104 1 0
001 10008 0 0 000108 0001011 1 000108 1 0
001 1000d 1 0 00010d 0011011 1 00010d 1 0
001 10005 0 0 000105 0011011 1 000105 0 0
001 10007 1 0 000107 0001011 0 000107 0 1
# same faults from the hit path
001 10001 1 1 000101 0001010 1 000101 1 0
001 10002 1 1 000102 0000011 1 000102 1 0
001 10004 1 1 000104 0001101 1 000104 1 0
001 10008 0 1 000108 0001011 1 000108 1 0
001 1000d 1 1 00010d 0011011 1 00010d 1 0
001 10005 0 1 000105 0011011 1 000105 0 0
001 10007 1 1 000107 0001011 0 000107 0 1
# ASID isolation and global pages
001 20000 1 0 000200 0101011 1 000200 0 0
041 20000 1 1 000200 0101011 1 000200 0 0
041 10000 1 0 000777 0001011 1 000777 0 0
041 10000 1 1 000777 0001011 1 000777 0 0
001 10000 1 1 000100 0001011 1 000100 0 0
011 20000 1 1 000200 0101011 1 000200 0 0
# replacement in one set
002 30000 1 0 000300 0001011 1 000300 0 0
002 30010 1 0 000310 0001011 1 000310 0 0
002 30020 1 0 000320 0001011 1 000320 0 0
002 30030 1 0 000330 0001011 1 000330 0 0
002 30000 1 1 000300 0001011 1 000300 0 0
002 30020 1 1 000320 0001011 1 000320 0 0
002 30040 1 0 000340 0001011 1 000340 0 0
002 30000 1 1 000300 0001011 1 000300 0 0
002 30020 1 1 000320 0001011 1 000320 0 0
002 30030 1 1 000330 0001011 1 000330 0 0
002 30040 1 1 000340 0001011 1 000340 0 0
002 30010 1 0 000310 0001011 1 000310 0 0

/* verification/itlb_tb.sv */
// instruction TLB testbench
// replays the golden lookup list against the DUT with a randomized L2 TLB model
module itlb_tb;
    import itlb_pkg::*;

    localparam int    CLK_PERIOD      = 100;
    localparam int    RESET_CYCLES    = 8;
    localparam int    CYCLES_PER_LINE = 20;
    localparam string GOLDEN_FILE     = "verification/itlb_golden.txt";

    // one golden lookup with the L2 answer and the expected response
    typedef struct packed {
        logic [ASID_WIDTH-1:0]      asid;
        logic [VPN_WIDTH-1:0]       vpn;
        logic [EXEC_MODE_WIDTH-1:0] exec_mode;
        logic                       expect_hit;
        pte_t                       pte;
        logic                       is_mem;
        core_resp_t                 expect_resp;
    } golden_line_t;

    // lookups in flight with the oldest first
    typedef struct packed {
        logic                  is_hit;
        logic [3:0]            l2_delay;
        logic [31:0]           strobe_cycle;
        logic [ASID_WIDTH-1:0] asid;
        logic [VPN_WIDTH-1:0]  vpn;
        pte_t                  pte;
        logic                  is_mem;
        core_resp_t            expect_resp;
    } pending_t;

    logic                  CLK;
    logic                  nRST;
    logic                  core_req_valid;
    lookup_req_t           core_req;
    logic                  core_resp_valid;
    core_resp_t            core_resp;
    logic                  l2_req_valid;
    logic [ASID_WIDTH-1:0] l2_req_asid;
    logic [VPN_WIDTH-1:0]  l2_req_vpn;
    logic                  l2_resp_valid;
    l2_resp_t              l2_resp;

    golden_line_t golden[$];
    pending_t     pending[$];
    logic         golden_loaded = 1'b0;
    int           cyc = 0;
    int           value_errors = 0;
    int           protocol_errors = 0;
    logic [31:0]  lfsr = 32'h7f7a3eb8;

    // L2 model state for the one outstanding miss
    logic         miss_pending = 1'b0;
    logic         l2_asked = 1'b0;
    logic         l2_answered = 1'b0;
    int           l2_wait = 0;
    int           answer_cycle = 0;
    l2_resp_t     l2_answer;

    itlb_top i_dut (
        .CLK(CLK),
        .nRST(nRST),
        .core_req_valid(core_req_valid),
        .core_req(core_req),
        .core_resp_valid(core_resp_valid),
        .core_resp(core_resp),
        .l2_req_valid(l2_req_valid),
        .l2_req_asid(l2_req_asid),
        .l2_req_vpn(l2_req_vpn),
        .l2_resp_valid(l2_resp_valid),
        .l2_resp(l2_resp)
    );

    initial CLK = 1'b0;
    always #(CLK_PERIOD / 2) CLK = ~CLK;

    always @(posedge CLK) cyc <= cyc + 1;

    // ----------------------------------------
    // helpers

    // right shifting Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
        return value;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
            value_errors++;
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR at time %0t: %s", $time, what);
        protocol_errors++;
    endtask

    task automatic retire_head();
        if (!pending[0].is_hit) begin
            miss_pending = 1'b0;
            l2_asked     = 1'b0;
            l2_answered  = 1'b0;
        end
        void'(pending.pop_front());
    endtask

    task automatic finish_run(input logic timed_out);
        $display("errors: %0d value, %0d protocol, timeout %0d",
            value_errors, protocol_errors, timed_out);
        if (!timed_out && value_errors == 0 && protocol_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // golden columns asid vpn mode hit ppn flags is_mem exp_ppn exp_pf exp_af
    // flags in dguxwrv order as binary
    task automatic read_golden();
        int           fd;
        int           count;
        string        text;
        logic [31:0]  f_asid, f_vpn, f_mode, f_hit, f_ppn;
        logic [31:0]  f_flags, f_mem, f_eppn, f_epf, f_eaf;
        golden_line_t line;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            report_error("cannot open the golden file");
            return;
        end
        while (!$feof(fd)) begin
            count = $fgets(text, fd);
            if (count == 0) begin
                break;
            end
            count = $sscanf(text, "%h %h %h %h %h %b %h %h %h %h", f_asid, f_vpn, f_mode,
                f_hit, f_ppn, f_flags, f_mem, f_eppn, f_epf, f_eaf);
            // comment and blank lines give fewer fields
            if (count == 10) begin
                line.asid                     = f_asid[ASID_WIDTH-1:0];
                line.vpn                      = f_vpn[VPN_WIDTH-1:0];
                line.exec_mode                = f_mode[EXEC_MODE_WIDTH-1:0];
                line.expect_hit               = f_hit[0];
                line.pte.ppn                  = f_ppn[PPN_WIDTH-1:0];
                line.pte.d                    = f_flags[6];
                line.pte.g                    = f_flags[5];
                line.pte.u                    = f_flags[4];
                line.pte.x                    = f_flags[3];
                line.pte.w                    = f_flags[2];
                line.pte.r                    = f_flags[1];
                line.pte.v                    = f_flags[0];
                line.is_mem                   = f_mem[0];
                line.expect_resp.ppn          = f_eppn[PPN_WIDTH-1:0];
                line.expect_resp.page_fault   = f_epf[0];
                line.expect_resp.access_fault = f_eaf[0];
                golden.push_back(line);
            end
        end
        $fclose(fd);
    endtask

    // ----------------------------------------
    // lookup driver
    initial begin : driver
        golden_line_t line;
        pending_t     entry;
        int           gap;
        nRST           = 1'b0;
        core_req_valid = 1'b0;
        core_req       = '0;
        l2_resp_valid  = 1'b0;
        l2_resp        = '0;
        l2_answer      = '0;
        read_golden();
        if (golden.size() == 0) begin
            report_error("the golden file holds no lookups");
            finish_run(1'b0);
        end else begin
            golden_loaded = 1'b1;
            repeat (RESET_CYCLES) @(negedge CLK);
            nRST = 1'b1;
            foreach (golden[i]) begin
                line = golden[i];
                gap  = take_bits(2);
                repeat (gap) begin
                    @(negedge CLK);
                    core_req_valid = 1'b0;
                end
                @(negedge CLK);
                core_req_valid     = 1'b1;
                core_req.asid      = line.asid;
                core_req.vpn       = line.vpn;
                core_req.exec_mode = line.exec_mode;
                entry.is_hit       = line.expect_hit;
                entry.l2_delay     = line.expect_hit ? 4'd0 : 4'(take_bits(3) + 1);
                entry.strobe_cycle = cyc;
                entry.asid         = line.asid;
                entry.vpn          = line.vpn;
                entry.pte          = line.pte;
                entry.is_mem       = line.is_mem;
                entry.expect_resp  = line.expect_resp;
                pending.push_back(entry);
                // no new lookup until the miss is answered
                if (!line.expect_hit) begin
                    miss_pending = 1'b1;
                    @(negedge CLK);
                    core_req_valid = 1'b0;
                    while (miss_pending) @(posedge CLK);
                end
            end
            @(negedge CLK);
            core_req_valid = 1'b0;
            while (pending.size() != 0) @(posedge CLK);
            repeat (4) @(negedge CLK);
            finish_run(1'b0);
        end
    end

    // ----------------------------------------
    // response monitor and L2 model sampled mid cycle
    always @(negedge CLK) begin : monitor
        pending_t head;
        logic     have_head;
        l2_resp_valid = 1'b0;
        have_head = (pending.size() > 0) && (pending[0].strobe_cycle < cyc);
        head = have_head ? pending[0] : '0;
        if (!nRST) begin
            check_value("core_resp_valid in reset", core_resp_valid, 0);
            check_value("l2_req_valid in reset", l2_req_valid, 0);
        end else begin
            if (l2_asked && !l2_answered) begin
                l2_wait--;
                if (l2_wait == 0) begin
                    l2_resp_valid = 1'b1;
                    l2_resp       = l2_answer;
                    l2_answered   = 1'b1;
                    answer_cycle  = cyc;
                end
            end
            if (l2_req_valid) begin
                if (have_head && !head.is_hit && !l2_asked) begin
                    check_value("l2 request asid", l2_req_asid, head.asid);
                    check_value("l2 request vpn", l2_req_vpn, head.vpn);
                    l2_asked         = 1'b1;
                    l2_wait          = head.l2_delay;
                    l2_answer.asid   = l2_req_asid;
                    l2_answer.vpn    = l2_req_vpn;
                    l2_answer.pte    = head.pte;
                    l2_answer.is_mem = head.is_mem;
                end else begin
                    report_error("L2 request strobe with no miss outstanding");
                end
            end
            if (core_resp_valid) begin
                if (!have_head) begin
                    report_error("core response strobe with no lookup outstanding");
                end else if (!head.is_hit && !l2_answered) begin
                    report_error("core response strobe before the L2 answered a miss");
                end else begin
                    if (!head.is_hit) begin
                        check_value("replay response cycle", cyc, answer_cycle + 2);
                    end
                    check_value("ppn", core_resp.ppn, head.expect_resp.ppn);
                    check_value("page fault", core_resp.page_fault,
                        head.expect_resp.page_fault);
                    check_value("access fault", core_resp.access_fault,
                        head.expect_resp.access_fault);
                    retire_head();
                end
            end else if (have_head) begin
                if (head.is_hit && cyc >= head.strobe_cycle + 1) begin
                    report_error("no core response for a lookup expected to hit");
                    retire_head();
                end else if (!head.is_hit && !l2_asked && cyc >= head.strobe_cycle + 1) begin
                    report_error("no L2 request for a lookup expected to miss");
                    retire_head();
                end else if (!head.is_hit && l2_answered && cyc >= answer_cycle + 2) begin
                    report_error("no core response after the L2 answer");
                    retire_head();
                end
            end
        end
    end

    // ----------------------------------------
    // watchdog sized from the golden length
    initial begin : watchdog
        wait (golden_loaded);
        #((golden.size() * CYCLES_PER_LINE + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: the golden sequence did not finish in %0d cycles",
            golden.size() * CYCLES_PER_LINE + RESET_CYCLES);
        finish_run(1'b1);
    end

endmodule

/* hdl/itlb_top.sv */
// instruction TLB top level
// joins the miss control, the set array and the lookup stage
module itlb_top #(
    parameter int ENTRIES = itlb_pkg::ITLB_ENTRIES_DEFAULT,
    parameter int ASSOC   = itlb_pkg::ITLB_ASSOC_DEFAULT
) (
    input  logic                            CLK,
    input  logic                            nRST,

    // core lookup
    input  logic                            core_req_valid,
    input  itlb_pkg::lookup_req_t           core_req,
    output logic                            core_resp_valid,
    output itlb_pkg::core_resp_t            core_resp,

    // L2 TLB
    output logic                            l2_req_valid,
    output logic [itlb_pkg::ASID_WIDTH-1:0] l2_req_asid,
    output logic [itlb_pkg::VPN_WIDTH-1:0]  l2_req_vpn,
    input  logic                            l2_resp_valid,
    input  itlb_pkg::l2_resp_t              l2_resp
);
    import itlb_pkg::*;

    localparam int WAY_WIDTH = $clog2(ASSOC);
    localparam int SET_WIDTH = ASSOC * $bits(itlb_entry_t) + ASSOC - 1;

    // array read
    logic                 read_valid;
    lookup_req_t          read_req;
    logic [SET_WIDTH-1:0] rd_set;

    // fill and PLRU writes
    logic                 fill_we;
    logic [WAY_WIDTH-1:0] fill_way;
    itlb_entry_t          fill_entry;
    logic                 plru_we;
    logic [ASSOC-2:0]     plru_bits;

    // lookup result
    logic                 lookup_done;
    logic                 hit;
    lookup_req_t          stage_req;
    logic [WAY_WIDTH-1:0] victim_way;

    itlb_ctrl #(
        .ASSOC(ASSOC)
    ) i_ctrl (
        .CLK(CLK),
        .nRST(nRST),
        .core_req_valid(core_req_valid),
        .core_req(core_req),
        .lookup_done(lookup_done),
        .hit(hit),
        .stage_req(stage_req),
        .victim_way(victim_way),
        .l2_resp_valid(l2_resp_valid),
        .l2_resp(l2_resp),
        .read_valid(read_valid),
        .read_req(read_req),
        .fill_we(fill_we),
        .fill_way(fill_way),
        .fill_entry(fill_entry),
        .l2_req_valid(l2_req_valid),
        .l2_req_asid(l2_req_asid),
        .l2_req_vpn(l2_req_vpn)
    );

    itlb_entry_array #(
        .ENTRIES(ENTRIES),
        .ASSOC(ASSOC)
    ) i_array (
        .CLK(CLK),
        .nRST(nRST),
        .read_valid(read_valid),
        .read_req(read_req),
        .rd_set(rd_set),
        .fill_we(fill_we),
        .fill_way(fill_way),
        .fill_entry(fill_entry),
        .plru_we(plru_we),
        .plru_bits(plru_bits)
    );

    itlb_lookup_stage #(
        .ASSOC(ASSOC)
    ) i_lookup (
        .CLK(CLK),
        .nRST(nRST),
        .read_valid(read_valid),
        .read_req(read_req),
        .rd_set(rd_set),
        .lookup_done(lookup_done),
        .hit(hit),
        .stage_req(stage_req),
        .victim_way(victim_way),
        .plru_we(plru_we),
        .plru_bits(plru_bits),
        .core_resp_valid(core_resp_valid),
        .core_resp(core_resp)
    );

endmodule

/* hdl/itlb_ctrl.sv */
// instruction TLB miss control
// requests the L2 TLB on a miss, writes the fill and replays the lookup
module itlb_ctrl #(
    parameter int ASSOC = itlb_pkg::ITLB_ASSOC_DEFAULT
) (
    input  logic                            CLK,
    input  logic                            nRST,

    // core lookup
    input  logic                            core_req_valid,
    input  itlb_pkg::lookup_req_t           core_req,

    // lookup stage result
    input  logic                            lookup_done,
    input  logic                            hit,
    input  itlb_pkg::lookup_req_t           stage_req,
    input  logic [$clog2(ASSOC)-1:0]        victim_way,

    // L2 response
    input  logic                            l2_resp_valid,
    input  itlb_pkg::l2_resp_t              l2_resp,

    // array read port
    output logic                            read_valid,
    output itlb_pkg::lookup_req_t           read_req,

    // array fill port
    output logic                            fill_we,
    output logic [$clog2(ASSOC)-1:0]        fill_way,
    output itlb_pkg::itlb_entry_t           fill_entry,

    // L2 request
    output logic                            l2_req_valid,
    output logic [itlb_pkg::ASID_WIDTH-1:0] l2_req_asid,
    output logic [itlb_pkg::VPN_WIDTH-1:0]  l2_req_vpn
);
    import itlb_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        MISS_WAIT,
        REPLAY
    } state_t;

    state_t                   state;
    state_t                   next_state;
    lookup_req_t              miss_req;
    logic [$clog2(ASSOC)-1:0] miss_way;
    logic                     miss;
    logic                     resp_match;

    // ----------------------------------------
    // miss detect and state

    // misses seen outside IDLE belong to stale lookups and are dropped
    assign miss = lookup_done && !hit && (state == IDLE);

    // responses for other pages are ignored
    assign resp_match = l2_resp_valid
        && (l2_resp.asid == miss_req.asid)
        && (l2_resp.vpn == miss_req.vpn);

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      if (miss) next_state = MISS_WAIT;
            MISS_WAIT: if (resp_match) next_state = REPLAY;
            REPLAY:    next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // missed request and the way it will land in
    always_ff @(posedge CLK) begin
        if (miss) begin
            miss_req <= stage_req;
            miss_way <= victim_way;
        end
    end

    assign l2_req_valid = miss;
    assign l2_req_asid  = stage_req.asid;
    assign l2_req_vpn   = stage_req.vpn;

    // ----------------------------------------
    // fill and replay

    assign fill_we  = (state == MISS_WAIT) && resp_match;
    assign fill_way = miss_way;

    always_comb begin
        fill_entry.valid  = 1'b1;
        fill_entry.asid   = miss_req.asid;
        fill_entry.vpn    = miss_req.vpn;
        fill_entry.pte    = l2_resp.pte;
        fill_entry.is_mem = l2_resp.is_mem;
    end

    // core is silent during replay so the read port needs no arbiter
    assign read_valid = core_req_valid || (state == REPLAY);
    assign read_req   = (state == REPLAY) ? miss_req : core_req;

    // core holds off new lookups until the miss is answered
    assert property (@(posedge CLK) disable iff (!nRST)
        core_req_valid |-> (state == IDLE));

    // the L2 answers the missed page only while the miss waits
    assert property (@(posedge CLK) disable iff (!nRST)
        resp_match |-> (state == MISS_WAIT));

endmodule

/* hdl/itlb_lookup_stage.sv */
// instruction TLB lookup stage
// way compare on the registered set, fault checks and the core response
module itlb_lookup_stage #(
    parameter int ASSOC = itlb_pkg::ITLB_ASSOC_DEFAULT
) (
    input  logic                            CLK,
    input  logic                            nRST,

    // request issued to the array this cycle
    input  logic                            read_valid,
    input  itlb_pkg::lookup_req_t           read_req,
    input  logic [ASSOC*$bits(itlb_pkg::itlb_entry_t)+ASSOC-2:0] rd_set,

    // result to the control
    output logic                            lookup_done,
    output logic                            hit,
    output itlb_pkg::lookup_req_t           stage_req,
    output logic [$clog2(ASSOC)-1:0]        victim_way,

    // PLRU write back
    output logic                            plru_we,
    output logic [ASSOC-2:0]                plru_bits,

    // core response
    output logic                            core_resp_valid,
    output itlb_pkg::core_resp_t            core_resp
);
    import itlb_pkg::*;

    localparam int WAY_WIDTH = $clog2(ASSOC);

    typedef struct packed {
        itlb_entry_t [ASSOC-1:0] entry_by_way;
        logic [ASSOC-2:0]        plru;
    } set_t;

    set_t                 cur_set;
    logic                 stage_valid;
    logic [ASSOC-1:0]     hit_by_way;
    logic [ASSOC-1:0]     valid_by_way;
    logic [WAY_WIDTH-1:0] hit_way;
    itlb_entry_t          hit_entry;

    // request follows the set read by one cycle
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= read_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (read_valid) begin
            stage_req <= read_req;
        end
    end

    assign cur_set = rd_set;

    // ----------------------------------------
    // way compare, global pages match any ASID
    always_comb begin
        hit_way   = '0;
        hit_entry = '0;
        for (int w = 0; w < ASSOC; w++) begin
            valid_by_way[w] = cur_set.entry_by_way[w].valid;
            hit_by_way[w]   = cur_set.entry_by_way[w].valid
                && (cur_set.entry_by_way[w].vpn == stage_req.vpn)
                && ((cur_set.entry_by_way[w].asid == stage_req.asid)
                    || cur_set.entry_by_way[w].pte.g);
            if (hit_by_way[w]) begin
                hit_way   = WAY_WIDTH'(w);
                hit_entry = cur_set.entry_by_way[w];
            end
        end
    end

    assign lookup_done = stage_valid;
    assign hit         = |hit_by_way;

    // ----------------------------------------
    // response and fault checks
    assign core_resp_valid = stage_valid && hit;

    always_comb begin
        core_resp.ppn          = hit_entry.pte.ppn;
        core_resp.page_fault   = !hit_entry.pte.v
            || !hit_entry.pte.x
            || (hit_entry.pte.w && !hit_entry.pte.r)
            || (!hit_entry.pte.u && (stage_req.exec_mode == MODE_USER))
            || (hit_entry.pte.u && (stage_req.exec_mode == MODE_SUPERVISOR));
        core_resp.access_fault = !hit_entry.is_mem;
    end

    assign plru_we = stage_valid && hit;

    itlb_plru #(
        .ASSOC(ASSOC)
    ) i_plru (
        .old_plru(cur_set.plru),
        .valid_by_way(valid_by_way),
        .touch_way(hit_way),
        .new_plru(plru_bits),
        .victim_way(victim_way)
    );

    // fills only follow a miss, so one page never sits in two ways
    assert property (@(posedge CLK) disable iff (!nRST)
        stage_valid |-> $onehot0(hit_by_way));

endmodule

/* hdl/itlb_entry_array.sv */
// instruction TLB set storage
// hashed set index, registered set read, entry fill and PLRU write ports
module itlb_entry_array #(
    parameter int ENTRIES = itlb_pkg::ITLB_ENTRIES_DEFAULT,
    parameter int ASSOC   = itlb_pkg::ITLB_ASSOC_DEFAULT
) (
    input  logic                            CLK,
    input  logic                            nRST,

    // read port
    input  logic                            read_valid,
    input  itlb_pkg::lookup_req_t           read_req,
    output logic [ASSOC*$bits(itlb_pkg::itlb_entry_t)+ASSOC-2:0] rd_set,

    // entry fill
    input  logic                            fill_we,
    input  logic [$clog2(ASSOC)-1:0]        fill_way,
    input  itlb_pkg::itlb_entry_t           fill_entry,

    // PLRU update for the last read set
    input  logic                            plru_we,
    input  logic [ASSOC-2:0]                plru_bits
);
    import itlb_pkg::*;

    localparam int NUM_SETS    = ENTRIES / ASSOC;
    localparam int INDEX_WIDTH = $clog2(NUM_SETS);

    typedef struct packed {
        itlb_entry_t [ASSOC-1:0] entry_by_way;
        logic [ASSOC-2:0]        plru;
    } set_t;

    set_t [NUM_SETS-1:0]    sets;
    set_t                   rd_set_q;
    logic [INDEX_WIDTH-1:0] read_index;
    logic [INDEX_WIDTH-1:0] fill_index;
    logic [INDEX_WIDTH-1:0] last_index;

    // low VPN bits folded with low ASID bits
    // spreads identical VPNs of different processes over the sets
    function automatic logic [INDEX_WIDTH-1:0] index_hash(
        input logic [ASID_WIDTH-1:0] asid,
        input logic [VPN_WIDTH-1:0]  vpn
    );
        return vpn[INDEX_WIDTH-1:0]
            ^ vpn[2*INDEX_WIDTH-1:INDEX_WIDTH]
            ^ asid[INDEX_WIDTH-1:0]
            ^ asid[2*INDEX_WIDTH-1:INDEX_WIDTH];
    endfunction

    assign read_index = index_hash(read_req.asid, read_req.vpn);
    assign fill_index = index_hash(fill_entry.asid, fill_entry.vpn);

    // ----------------------------------------
    // storage, all ways invalid out of reset
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            sets <= '0;
        end else begin
            if (fill_we) begin
                sets[fill_index].entry_by_way[fill_way] <= fill_entry;
            end
            if (plru_we) begin
                sets[last_index].plru <= plru_bits;
            end
        end
    end

    // ----------------------------------------
    // registered set read
    always_ff @(posedge CLK) begin
        if (read_valid) begin
            rd_set_q   <= sets[read_index];
            last_index <= read_index;
            // back-to-back hits on one set see the PLRU written this same edge
            if (plru_we && (last_index == read_index)) begin
                rd_set_q.plru <= plru_bits;
            end
        end
    end

    assign rd_set = rd_set_q;

    // fills only land while the control holds lookups off
    assert property (@(posedge CLK) disable iff (!nRST)
        !(fill_we && read_valid));

endmodule

/* hdl/itlb_plru.sv */
// tree pseudo-LRU for one set
// tree bits after a touch, and the victim way for the next fill
module itlb_plru #(
    parameter int ASSOC = 4
) (
    input  logic [ASSOC-2:0]         old_plru,
    input  logic [ASSOC-1:0]         valid_by_way,
    input  logic [$clog2(ASSOC)-1:0] touch_way,
    output logic [ASSOC-2:0]         new_plru,
    output logic [$clog2(ASSOC)-1:0] victim_way
);
    localparam int WAY_WIDTH = $clog2(ASSOC);

    logic [WAY_WIDTH-1:0] tree_way;
    logic [WAY_WIDTH-1:0] invalid_way;
    logic                 any_invalid;

    // ----------------------------------------
    // tree layout
    // node n has children 2n+1 for the lower ways and 2n+2 for the upper
    // a node bit of 1 sends the victim search to the upper half
    // way bits are taken msb first from the root down

    // point every node on the touched path away from it
    always_comb begin
        int node;
        new_plru = old_plru;
        node     = 0;
        for (int lvl = WAY_WIDTH - 1; lvl >= 0; lvl--) begin
            new_plru[node] = ~touch_way[lvl];
            node = 2 * node + 1 + int'(touch_way[lvl]);
        end
    end

    // follow the node bits from the root
    always_comb begin
        int node;
        tree_way = '0;
        node     = 0;
        for (int lvl = WAY_WIDTH - 1; lvl >= 0; lvl--) begin
            tree_way[lvl] = old_plru[node];
            node = 2 * node + 1 + int'(old_plru[node]);
        end
    end

    // lowest empty way wins over the tree
    always_comb begin
        any_invalid = 1'b0;
        invalid_way = '0;
        for (int w = ASSOC - 1; w >= 0; w--) begin
            if (!valid_by_way[w]) begin
                any_invalid = 1'b1;
                invalid_way = WAY_WIDTH'(w);
            end
        end
    end

    assign victim_way = any_invalid ? invalid_way : tree_way;

endmodule

/* hdl/itlb_pkg.sv */
// Sv32 instruction TLB shared definitions
// page number widths, privilege encodings and the structs passed between blocks
package itlb_pkg;

    // ----------------------------------------
    // Sv32 widths
    localparam int VPN_WIDTH       = 20;
    localparam int PPN_WIDTH       = 22;
    localparam int ASID_WIDTH      = 9;
    localparam int EXEC_MODE_WIDTH = 2;

    // privilege mode of the fetch
    localparam logic [EXEC_MODE_WIDTH-1:0] MODE_USER       = 2'd0;
    localparam logic [EXEC_MODE_WIDTH-1:0] MODE_SUPERVISOR = 2'd1;

    // default geometry, 4 sets of 4 ways
    localparam int ITLB_ENTRIES_DEFAULT = 16;
    localparam int ITLB_ASSOC_DEFAULT   = 4;

    // ----------------------------------------
    // leaf PTE fields kept per entry
    // RSW and A are not stored, A is always set for anything in a TLB
    typedef struct packed {
        logic [PPN_WIDTH-1:0] ppn;
        logic                 d;
        // global mapping, skips the ASID compare
        logic                 g;
        logic                 u;
        logic                 x;
        logic                 w;
        logic                 r;
        logic                 v;
    } pte_t;

    // one way of a set
    // full VPN as tag since the index is a hash, not a bit slice
    typedef struct packed {
        logic                  valid;
        logic [ASID_WIDTH-1:0] asid;
        logic [VPN_WIDTH-1:0]  vpn;
        pte_t                  pte;
        logic                  is_mem;  // PMA, main memory region
    } itlb_entry_t;

    // ----------------------------------------
    // request and response words
    typedef struct packed {
        logic [ASID_WIDTH-1:0]      asid;
        logic [VPN_WIDTH-1:0]       vpn;
        logic [EXEC_MODE_WIDTH-1:0] exec_mode;
    } lookup_req_t;

    typedef struct packed {
        logic [ASID_WIDTH-1:0] asid;
        logic [VPN_WIDTH-1:0]  vpn;
        pte_t                  pte;
        logic                  is_mem;
    } l2_resp_t;

    typedef struct packed {
        logic [PPN_WIDTH-1:0] ppn;
        logic                 page_fault;
        logic                 access_fault;
    } core_resp_t;

endpackage
